//--- Bender.yml
package:
  name: cpusystem

sources:
  - files:
      - design/cpuPkg.sv
      - design/regFile.sv
      - design/insnDecoder.sv
      - design/aluExec.sv
      - design/cpuCore.sv
      - design/dataRam.sv
      - design/cpuSystem.sv
  - target: test
    files:
      - testbench/cpuSystem_asserts.sv
      - testbench/cpuSystem_tb.sv

//--- all.f
design/cpuPkg.sv
design/regFile.sv
design/insnDecoder.sv
design/aluExec.sv
design/cpuCore.sv
design/dataRam.sv
design/cpuSystem.sv
testbench/cpuSystem_asserts.sv
testbench/cpuSystem_tb.sv

//--- design/aluExec.sv
`timescale 1ns/1ps

module aluExec (
    input  logic                         clk,
    input  logic                         en,
    input  logic                         immRight,
    input  cpuPkg::opcode                op,
    input  logic [cpuPkg::wordWidth-1:0] x,
    input  logic [cpuPkg::wordWidth-1:0] y,
    input  logic [cpuPkg::wordWidth-1:0] imm,
    output logic [cpuPkg::wordWidth-1:0] rhs
);

    localparam int W = cpuPkg::wordWidth;

    logic [W-1:0] operand;  // Right side of op
    logic [W-1:0] addend;   // Term added after op
    logic [W-1:0] opResult;

    assign operand = immRight ? imm : y;
    assign addend  = immRight ? y : imm;

    always_comb begin
        case (op)
            cpuPkg::opOr:    opResult = x | operand;
            cpuPkg::opAnd:   opResult = x & operand;
            cpuPkg::opAdd:   opResult = x + operand;
            cpuPkg::opMul:   opResult = x * operand; // Low word only
            cpuPkg::opShl:   opResult = x << operand; // 32 and up gives zero
            cpuPkg::opLt:    opResult = {W{$signed(x) < $signed(operand)}};
            cpuPkg::opEq:    opResult = {W{x == operand}};
            cpuPkg::opGt:    opResult = {W{$signed(x) > $signed(operand)}};
            cpuPkg::opAndn:  opResult = x & ~operand;
            cpuPkg::opXor:   opResult = x ^ operand;
            cpuPkg::opSub:   opResult = x - operand;
            cpuPkg::opXnor:  opResult = x ^ ~operand;
            cpuPkg::opShr:   opResult = x >> operand; // Logical
            cpuPkg::opNe:    opResult = {W{x != operand}};
            cpuPkg::opRes4:  opResult = '0;
            cpuPkg::opRes15: opResult = '0;
            default:         opResult = '0;
        endcase
    end

    // Captured at the end of phase A
    always_ff @(posedge clk) begin
        if (en) begin
            rhs <= opResult + addend;
        end
    end

endmodule

//--- design/cpuCore.sv
`timescale 1ns/1ps

module cpuCore (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         en,
    input  logic                         haltReq,
    output logic [cpuPkg::wordWidth-1:0] insnAddr,
    input  logic [cpuPkg::wordWidth-1:0] insnData,
    output logic                         halted,
    output logic                         memWrite,
    output logic [cpuPkg::wordWidth-1:0] dataAddr,
    output logic [cpuPkg::wordWidth-1:0] writeData,
    input  logic [cpuPkg::wordWidth-1:0] readData
);

    logic [3:0]                   indexZ, indexX, indexY;
    logic [cpuPkg::wordWidth-1:0] valueZ, valueX, valueY;
    logic [cpuPkg::wordWidth-1:0] imm, rhs, writeValue;
    cpuPkg::opcode                op;
    logic                         immRight, storing, deref, illegal, branch;
    logic                         phaseB;  // Second cycle of the instruction
    logic                         paused;  // Holding in phase A on haltReq
    logic                         execA, execB;

    assign execA = en && !phaseB && !paused && !halted;
    assign execB = en && phaseB;

    // Loads take memory data, everything else takes the ALU result
    assign writeValue = deref ? readData : rhs;
    assign dataAddr   = deref ? rhs : valueZ;
    assign writeData  = deref ? valueZ : rhs;
    assign memWrite   = execB && storing;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            insnAddr <= cpuPkg::resetVector;
            halted   <= 1'b0;
            phaseB   <= 1'b0;
            paused   <= 1'b0;
        end else if (en) begin
            if (phaseB) begin
                phaseB   <= 1'b0;
                paused   <= haltReq; // Finish B, then wait in A
                insnAddr <= branch ? writeValue : insnAddr + 32'd1;
            end else if (paused) begin
                paused <= haltReq;
            end else if (!halted) begin
                if (illegal) begin
                    halted <= 1'b1; // Sticky until reset
                end else begin
                    phaseB <= 1'b1;
                end
            end
        end
    end

    insnDecoder insnDecoder_inst (
        .insn     (insnData),
        .indexZ   (indexZ),
        .indexX   (indexX),
        .indexY   (indexY),
        .imm      (imm),
        .op       (op),
        .immRight (immRight),
        .storing  (storing),
        .deref    (deref),
        .illegal  (illegal),
        .branch   (branch)
    );

    regFile regFile_inst (
        .clk       (clk),
        .writeEn   (execB && !storing),
        .indexZ    (indexZ),
        .indexX    (indexX),
        .indexY    (indexY),
        .writeData (writeValue),
        .pc        (insnAddr),
        .valueZ    (valueZ),
        .valueX    (valueX),
        .valueY    (valueY)
    );

    aluExec aluExec_inst (
        .clk      (clk),
        .en       (execA),
        .immRight (immRight),
        .op       (op),
        .x        (valueX),
        .y        (valueY),
        .imm      (imm),
        .rhs      (rhs)
    );

endmodule

//--- design/cpuPkg.sv
package cpuPkg;

    // Datapath and address width
    localparam int wordWidth = 32;

    localparam logic [wordWidth-1:0] resetVector = 32'h0000_1000; // First fetch address

    // Special register indices
    localparam logic [3:0] pcIndex   = 4'd15; // Reads pc+1, write is a branch
    localparam logic [3:0] zeroIndex = 4'd0;  // Reads zero, writes dropped

    // Instruction word layout
    localparam int typeBit  = 30; // Immediate on the right of op
    localparam int storeBit = 29;
    localparam int derefBit = 28;
    localparam int zLsb     = 24;
    localparam int xLsb     = 20;
    localparam int yLsb     = 16;
    localparam int opLsb    = 12;
    localparam int immWidth = 12; // Sign-extended, bits 11:0

    // Operation codes of the ALU stage
    typedef enum logic [3:0] {
        opOr    = 4'd0,
        opAnd   = 4'd1,
        opAdd   = 4'd2,
        opMul   = 4'd3,
        opRes4  = 4'd4,  // Reserved
        opShl   = 4'd5,
        opLt    = 4'd6,
        opEq    = 4'd7,
        opGt    = 4'd8,
        opAndn  = 4'd9,
        opXor   = 4'd10,
        opSub   = 4'd11,
        opXnor  = 4'd12,
        opShr   = 4'd13,
        opNe    = 4'd14,
        opRes15 = 4'd15  // Reserved
    } opcode;

endpackage

//--- design/cpuSystem.sv
`timescale 1ns/1ps

module cpuSystem #(
    parameter int ramAddrBits = 8
) (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         en,
    input  logic                         haltReq,
    input  logic [cpuPkg::wordWidth-1:0] insnData,
    output logic [cpuPkg::wordWidth-1:0] insnAddr,
    output logic                         halted,
    output logic                         memWrite,
    output logic [cpuPkg::wordWidth-1:0] dataAddr,
    output logic [cpuPkg::wordWidth-1:0] writeData
);

    logic [cpuPkg::wordWidth-1:0] readData; // RAM to core

    cpuCore cpuCore_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .en        (en),
        .haltReq   (haltReq),
        .insnAddr  (insnAddr),
        .insnData  (insnData),
        .halted    (halted),
        .memWrite  (memWrite),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .readData  (readData)
    );

    dataRam #(
        .ramAddrBits (ramAddrBits)
    ) dataRam_inst (
        .clk       (clk),
        .writeEn   (memWrite),
        .addr      (dataAddr),
        .writeData (writeData),
        .readData  (readData)
    );

endmodule

//--- design/dataRam.sv
`timescale 1ns/1ps

module dataRam #(
    parameter int ramAddrBits = 8
) (
    input  logic                         clk,
    input  logic                         writeEn,
    input  logic [cpuPkg::wordWidth-1:0] addr,
    input  logic [cpuPkg::wordWidth-1:0] writeData,
    output logic [cpuPkg::wordWidth-1:0] readData
);

    logic [cpuPkg::wordWidth-1:0] mem [2**ramAddrBits];
    logic [ramAddrBits-1:0]       wordIndex;

    // Upper address bits are ignored
    assign wordIndex = addr[ramAddrBits-1:0];

    assign readData = mem[wordIndex]; // Asynchronous read

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[wordIndex] <= writeData;
        end
    end

endmodule

//--- design/insnDecoder.sv
`timescale 1ns/1ps

module insnDecoder (
    input  logic [cpuPkg::wordWidth-1:0] insn,
    output logic [3:0]                   indexZ,
    output logic [3:0]                   indexX,
    output logic [3:0]                   indexY,
    output logic [cpuPkg::wordWidth-1:0] imm,
    output cpuPkg::opcode                op,
    output logic                         immRight,
    output logic                         storing,
    output logic                         deref,
    output logic                         illegal,
    output logic                         branch
);

    logic [cpuPkg::immWidth-1:0] immField;

    assign immRight = insn[cpuPkg::typeBit];
    assign storing  = insn[cpuPkg::storeBit];
    assign deref    = insn[cpuPkg::derefBit];

    assign indexZ = insn[cpuPkg::zLsb +: 4];
    assign indexX = insn[cpuPkg::xLsb +: 4];
    assign indexY = insn[cpuPkg::yLsb +: 4];
    assign op     = cpuPkg::opcode'(insn[cpuPkg::opLsb +: 4]);

    assign immField = insn[cpuPkg::immWidth-1:0];
    assign imm      = {{(cpuPkg::wordWidth - cpuPkg::immWidth){immField[cpuPkg::immWidth-1]}},
                       immField}; // Sign extend

    // All-ones word is the illegal instruction
    assign illegal = &insn;

    // A register write that targets the PC
    assign branch = (indexZ == cpuPkg::pcIndex) && !storing;

endmodule

//--- design/regFile.sv
`timescale 1ns/1ps

module regFile (
    input  logic                         clk,
    input  logic                         writeEn,
    input  logic [3:0]                   indexZ,
    input  logic [3:0]                   indexX,
    input  logic [3:0]                   indexY,
    input  logic [cpuPkg::wordWidth-1:0] writeData,
    input  logic [cpuPkg::wordWidth-1:0] pc,
    output logic [cpuPkg::wordWidth-1:0] valueZ,
    output logic [cpuPkg::wordWidth-1:0] valueX,
    output logic [cpuPkg::wordWidth-1:0] valueY
);

    logic [cpuPkg::wordWidth-1:0] regs [1:14]; // Only the general registers are stored
    logic [cpuPkg::wordWidth-1:0] pcNext;

    assign pcNext = pc + 32'd1;

    // Three independent read ports
    assign valueZ = (indexZ == cpuPkg::zeroIndex) ? '0 :
                    (indexZ == cpuPkg::pcIndex)   ? pcNext : regs[indexZ];
    assign valueX = (indexX == cpuPkg::zeroIndex) ? '0 :
                    (indexX == cpuPkg::pcIndex)   ? pcNext : regs[indexX];
    assign valueY = (indexY == cpuPkg::zeroIndex) ? '0 :
                    (indexY == cpuPkg::pcIndex)   ? pcNext : regs[indexY];

    always_ff @(posedge clk) begin
        if (writeEn && indexZ != cpuPkg::zeroIndex && indexZ != cpuPkg::pcIndex) begin
            regs[indexZ] <= writeData; // PC writes go through the sequencer
        end
    end

endmodule

//--- testbench/cpuSystem_asserts.sv
`timescale 1ns/1ps

module cpuSystem_asserts (
    input logic        clk,
    input logic        reset_n,
    input logic        memWrite,
    input logic        halted,
    input logic [31:0] insnAddr
);

    int failCount = 0; // Number of assertion failures

    // A store occupies a single phase B cycle
    assert property (@(posedge clk) disable iff (!reset_n) memWrite |=> !memWrite)
        else begin
            failCount++;
            $error("memWrite high in two consecutive cycles");
        end

    assert property (@(posedge clk) halted && reset_n |=> halted)
        else begin
            failCount++;
            $error("halted fell without a reset");
        end

    assert property (@(posedge clk) halted && reset_n |=> $stable(insnAddr))
        else begin
            failCount++;
            $error("insnAddr moved while halted");
        end

    // Reset returns the sequencer to phase A
    assert property (@(posedge clk) !reset_n |=> !memWrite)
        else begin
            failCount++;
            $error("memWrite high in the cycle after reset");
        end

endmodule

bind cpuCore cpuSystem_asserts cpuSystem_asserts_inst (
    .clk      (clk),
    .reset_n  (reset_n),
    .memWrite (memWrite),
    .halted   (halted),
    .insnAddr (insnAddr)
);

//--- testbench/cpuSystem_tb.sv
`timescale 1ns/1ps

module cpuSystem_tb;

    localparam int waitLimit = 100; // Cycles allowed per wait

    logic        clk = 1'b0;
    logic        reset_n = 1'b0;
    logic        en = 1'b0;
    logic        haltReq = 1'b0;
    logic        halted, memWrite;
    logic [31:0] insnData, insnAddr, dataAddr, writeData;
    logic [31:0] prog [256];
    logic [31:0] rngState = 32'h86719373;
    int          progLen;

    always #50 clk = ~clk;

    assign insnData = prog[insnAddr[7:0]]; // resetVector maps to word 0

    cpuSystem #(.ramAddrBits(8)) cpuSystem_inst (.*);

    function automatic logic [31:0] encode(input logic immRight, storing, deref,
                                           input logic [3:0] z, x, y, op,
                                           input logic [11:0] imm);
        return {1'b0, immRight, storing, deref, z, x, y, op, imm};
    endfunction

    function automatic logic [31:0] signExtend(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    function logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Expected op result, before the remaining term is added
    function automatic logic [31:0] aluModel(input logic [3:0] op, input logic [31:0] a, b);
        case (op)
            cpuPkg::opOr:   return a | b;
            cpuPkg::opAnd:  return a & b;
            cpuPkg::opAdd:  return a + b;
            cpuPkg::opMul:  return a * b;
            cpuPkg::opShl:  return (b > 31) ? 32'd0 : a << b[4:0];
            cpuPkg::opLt:   return ($signed(a) < $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
            cpuPkg::opEq:   return (a == b) ? 32'hFFFF_FFFF : 32'd0;
            cpuPkg::opGt:   return ($signed(a) > $signed(b)) ? 32'hFFFF_FFFF : 32'd0;
            cpuPkg::opAndn: return a & ~b;
            cpuPkg::opXor:  return a ^ b;
            cpuPkg::opSub:  return a - b;
            cpuPkg::opXnor: return ~(a ^ b);
            cpuPkg::opShr:  return (b > 31) ? 32'd0 : a >> b[4:0];
            cpuPkg::opNe:   return (a != b) ? 32'hFFFF_FFFF : 32'd0;
            default:        return 32'd0; // Reserved codes
        endcase
    endfunction

    task automatic emit(input logic [31:0] word);
        prog[progLen] = word;
        progLen++;
    endtask

    // Pieces of 10, 11 and 11 bits keep every immediate positive
    task automatic loadWord(input logic [3:0] r, input logic [31:0] v);
        emit(encode(1'b1, 1'b0, 1'b0, r, 4'd0, 4'd0, cpuPkg::opOr, {2'b0, v[31:22]}));
        emit(encode(1'b1, 1'b0, 1'b0, r, r, 4'd0, cpuPkg::opShl, 12'd11));
        emit(encode(1'b1, 1'b0, 1'b0, r, r, 4'd0, cpuPkg::opOr, {1'b0, v[21:11]}));
        emit(encode(1'b1, 1'b0, 1'b0, r, r, 4'd0, cpuPkg::opShl, 12'd11));
        emit(encode(1'b1, 1'b0, 1'b0, r, r, 4'd0, cpuPkg::opOr, {1'b0, v[10:0]}));
    endtask

    task automatic startReset();
        @(posedge clk);
        reset_n <= 1'b0;
        en      <= 1'b0;
        haltReq <= 1'b0;
        @(negedge clk); // Program is rewritten away from the clock edge
        progLen = 0;
    endtask

    task automatic finishReset(input logic runEnable);
        repeat (5) @(posedge clk);
        reset_n <= 1'b1;
        en      <= runEnable;
    endtask

    task automatic checkValue(input logic [31:0] actual, expected, input string what);
        if (actual !== expected) begin
            $display("[FAIL] %0t: %s: got %h, expected %h", $time, what, actual, expected);
            $display("*** FAILED ***");
            $fatal(1, "Value mismatch");
        end
    endtask

    task automatic tick(inout int cycles, input string what);
        @(negedge clk);
        cycles++;
        if (cycles > waitLimit) begin
            $display("Timed out after %0d cycles waiting for %s", waitLimit, what);
            $display("*** FAILED ***");
            $fatal(1, "Timeout");
        end
    endtask

    task automatic waitStore(input logic [31:0] expData, expAddr, input string what);
        int cycles;
        cycles = 0;
        do begin
            tick(cycles, "a memory write");
        end while (!memWrite);
        checkValue(writeData, expData, {what, " data"});
        checkValue(dataAddr, expAddr, {what, " address"});
    endtask

    task automatic waitFetch(input logic [31:0] fromAddr, expAddr, input string what);
        int cycles;
        cycles = 0;
        do begin
            tick(cycles, "a new fetch address");
        end while (insnAddr === fromAddr);
        checkValue(insnAddr, expAddr, what);
    endtask

    task automatic waitHalted();
        int cycles;
        cycles = 0;
        do begin
            tick(cycles, "halted to rise");
        end while (!halted);
    endtask

    task automatic testReset();
        startReset();
        emit(32'hFFFF_FFFF);
        finishReset(1'b0);
        @(negedge clk);
        checkValue(insnAddr, cpuPkg::resetVector, "insnAddr after reset");
        checkValue(32'(halted), 32'd0, "halted after reset");
        checkValue(32'(memWrite), 32'd0, "memWrite after reset");
    endtask

    task automatic testRegisters();
        logic [11:0] imm [0:14];
        int r;
        startReset();
        for (r = 1; r <= 14; r++) begin
            imm[r] = 12'(nextRand());
            emit(encode(1'b1, 1'b0, 1'b0, 4'(r), 4'd0, 4'd0, cpuPkg::opAdd, imm[r]));
        end
        emit(encode(1'b1, 1'b0, 1'b0, 4'd0, 4'd0, 4'd0, cpuPkg::opAdd, 12'h5A5)); // Dropped
        for (r = 0; r <= 14; r++) begin
            emit(encode(1'b1, 1'b1, 1'b1, 4'(r), 4'd0, 4'd0, cpuPkg::opAdd, 12'(32'h100 + r)));
        end
        emit(32'hFFFF_FFFF);
        finishReset(1'b1);
        for (r = 0; r <= 14; r++) begin
            waitStore((r == 0) ? 32'd0 : signExtend(imm[r]), 32'h100 + r,
                      $sformatf("store of register %0d", r));
        end
    endtask

    task automatic testAlu();
        logic [31:0] x, y, expect0 [16], expect1 [16];
        logic [11:0] imm0, imm1;
        int op;
        startReset();
        for (op = 0; op < 16; op++) begin
            x = nextRand();
            y = nextRand();
            imm0 = 12'(nextRand());
            imm1 = 12'(nextRand());
            if (op == cpuPkg::opShl || op == cpuPkg::opShr) begin
                y = y & 32'h3F; // Amounts around the word width
                imm1 = imm1 & 12'h03F;
            end
            if (op == cpuPkg::opEq || op == cpuPkg::opNe) begin
                y = x; // True compare through Y
            end
            expect0[op] = aluModel(4'(op), x, y) + signExtend(imm0);
            expect1[op] = aluModel(4'(op), x, signExtend(imm1)) + y;
            loadWord(4'd1, x);
            loadWord(4'd2, y);
            emit(encode(1'b0, 1'b1, 1'b0, 4'd0, 4'd1, 4'd2, 4'(op), imm0)); // mem[r0] gets rhs
            emit(encode(1'b1, 1'b1, 1'b0, 4'd0, 4'd1, 4'd2, 4'(op), imm1));
        end
        emit(32'hFFFF_FFFF);
        finishReset(1'b1);
        for (op = 0; op < 16; op++) begin
            waitStore(expect0[op], 32'd0, $sformatf("opcode %0d with Y", op));
            waitStore(expect1[op], 32'd0, $sformatf("opcode %0d with immediate", op));
        end
    endtask

    task automatic testLoadStore();
        logic [31:0] word;
        startReset();
        word = nextRand();
        loadWord(4'd3, word);
        emit(encode(1'b1, 1'b1, 1'b1, 4'd3, 4'd0, 4'd0, cpuPkg::opAdd, 12'h040)); // Store r3
        emit(encode(1'b1, 1'b0, 1'b1, 4'd4, 4'd0, 4'd0, cpuPkg::opAdd, 12'h040)); // Load r4
        emit(encode(1'b1, 1'b1, 1'b1, 4'd4, 4'd0, 4'd0, cpuPkg::opAdd, 12'h041));
        emit(32'hFFFF_FFFF);
        finishReset(1'b1);
        waitStore(word, 32'h40, "deref store");
        waitStore(word, 32'h41, "store after load");
    endtask

    task automatic testBranch();
        logic [31:0] target;
        int i;
        startReset();
        target = cpuPkg::resetVector + 32'd9;
        emit(encode(1'b1, 1'b0, 1'b0, 4'd15, 4'd15, 4'd0, cpuPkg::opAdd, 12'd8)); // pc+1+8
        for (i = 0; i < 8; i++) begin
            emit(32'hFFFF_FFFF); // Halts here if the branch is missed
        end
        emit(encode(1'b1, 1'b1, 1'b1, 4'd15, 4'd0, 4'd0, cpuPkg::opAdd, 12'h050));
        emit(32'hFFFF_FFFF);
        finishReset(1'b1);
        waitFetch(cpuPkg::resetVector, target, "fetch after branch");
        waitStore(target + 32'd1, 32'h50, "store of register 15");
    endtask

    task automatic testHalt();
        logic [31:0] heldAddr, badAddr;
        int i;
        startReset();
        for (i = 0; i < 6; i++) begin
            emit(encode(1'b1, 1'b0, 1'b0, 4'd1, 4'd1, 4'd0, cpuPkg::opAdd, 12'd1));
        end
        emit(32'hFFFF_FFFF);
        emit(encode(1'b1, 1'b1, 1'b1, 4'd1, 4'd0, 4'd0, cpuPkg::opAdd, 12'h060)); // Never runs
        finishReset(1'b1);
        haltReq <= 1'b1;
        heldAddr = cpuPkg::resetVector + 32'd1;
        badAddr = cpuPkg::resetVector + 32'd6;
        waitFetch(cpuPkg::resetVector, heldAddr, "address when pause begins");
        repeat (8) @(negedge clk);
        checkValue(insnAddr, heldAddr, "insnAddr during pause");
        @(posedge clk);
        haltReq <= 1'b0;
        waitFetch(heldAddr, heldAddr + 32'd1, "address after pause");
        waitHalted();
        checkValue(insnAddr, badAddr, "insnAddr at illegal word");
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            checkValue(32'(memWrite), 32'd0, "memWrite while halted");
            checkValue(insnAddr, badAddr, "insnAddr while halted");
        end
    endtask

    // Watch the bound sequencing checker
    always @(negedge clk) begin
        if (cpuSystem_inst.cpuCore_inst.cpuSystem_asserts_inst.failCount != 0) begin
            $display("A sequencing assertion failed before %0t", $time);
            $display("*** FAILED ***");
            $fatal(1, "Assertion failure");
        end
    end

    initial begin
        foreach (prog[i]) begin
            prog[i] = 32'(i); // Filler decodes as a write to register 0
        end
        testReset();
        testRegisters();
        testAlu();
        testLoadStore();
        testBranch();
        testHalt();
        if (cpuSystem_inst.cpuCore_inst.cpuSystem_asserts_inst.failCount != 0) begin
            $display("A sequencing assertion failed during the run");
            $display("*** FAILED ***");
            $fatal(1, "Assertion failure");
        end else begin
            $display("*** PASSED ***");
            $finish;
        end
    end

endmodule
